/* hw/dm_abstract_cmd.sv */
// ----------------------------------------
// command register, cmderr field and abstract data registers
// all state is held at zero while dmactive is low
// a command write is taken even with cmderr set
// ----------------------------------------

`timescale 1ns/100ps

`include "dm_defs.svh"

module dm_abstract_cmd import dm_pkg::*; (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  logic                                 dmactive_i,
  input  logic                                 wr_command_i,
  input  logic                                 wr_abstractcs_i,
  input  logic                                 wr_data_i,
  input  logic                                 rd_data_i,
  input  logic [$clog2(`DM_DATA_COUNT)-1:0]    data_idx_i,
  input  dmi_data_t                            req_data_i,
  input  logic                                 cmdbusy_i,
  input  logic                                 cmderror_valid_i,
  input  cmderr_e                              cmderror_i,
  input  logic                                 data_valid_i,
  input  dmi_data_t [`DM_DATA_COUNT-1:0]       data_i,
  output dmi_data_t                            abstractcs_o,
  output dmi_data_t                            data_rd_o,
  output logic                                 cmd_valid_o,
  output dmi_data_t                            cmd_o,
  output dmi_data_t [`DM_DATA_COUNT-1:0]       data_o
);

  logic                            any_access;
  logic                            cmd_valid_q;
  cmderr_e                         cmderr_q;
  cmderr_e                         cmderr_d;
  dmi_data_t                       command_q;
  dmi_data_t [`DM_DATA_COUNT-1:0]  data_q;

  assign any_access = wr_command_i | wr_abstractcs_i | wr_data_i | rd_data_i;

  // ----------------------------------------
  // cmderr
  // ----------------------------------------
  always_comb begin
    cmderr_d = cmderr_q;
    if (cmdbusy_i) begin
      // only the first error is kept
      if (any_access && cmderr_q == cmderr_none) begin
        cmderr_d = cmderr_busy;
      end
    end else if (wr_abstractcs_i) begin
      // write 1 to clear
      cmderr_d = cmderr_e'(cmderr_q & ~req_data_i[10:8]);
    end
    // an error reported by the hart beats any DMI update
    if (cmderror_valid_i) begin
      cmderr_d = cmderror_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cmderr_q    <= cmderr_none;
      cmd_valid_q <= 1'b0;
    end else if (!dmactive_i) begin
      cmderr_q    <= cmderr_none;
      cmd_valid_q <= 1'b0;
    end else begin
      cmderr_q    <= cmderr_d;
      cmd_valid_q <= wr_command_i & ~cmdbusy_i;
    end
  end

  // ----------------------------------------
  // command and data words
  // ----------------------------------------
  always_ff @(posedge clk_i) begin
    if (!dmactive_i) begin
      command_q <= '0;
      data_q    <= '0;
    end else begin
      if (wr_command_i && !cmdbusy_i) begin
        command_q <= req_data_i;
      end
      // results from the hart overwrite a DMI write in the same cycle
      if (data_valid_i) begin
        data_q <= data_i;
      end else if (wr_data_i && !cmdbusy_i) begin
        data_q[data_idx_i] <= req_data_i;
      end
    end
  end

  // progbufsize is zero
  assign abstractcs_o = {19'b0, cmdbusy_i, 1'b0, cmderr_q, 4'b0, 4'(`DM_DATA_COUNT)};

  assign data_rd_o   = data_q[data_idx_i];
  assign cmd_valid_o = cmd_valid_q;
  assign cmd_o       = command_q;
  assign data_o      = data_q;

endmodule

/* hw/dm_csrs.sv */
// ----------------------------------------
// DMI register front end of the debug module
// every accepted request returns one response word, in order
// writes and nops answer with zero, command reads as zero
// ----------------------------------------

`timescale 1ns/100ps

`include "dm_defs.svh"

module dm_csrs import dm_pkg::*; (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  // DMI
  input  logic                            dmi_req_valid_i,
  output logic                            dmi_req_ready_o,
  input  dmi_addr_t                       dmi_req_addr_i,
  input  dtm_op_e                         dmi_req_op_i,
  input  dmi_data_t                       dmi_req_data_i,
  output logic                            dmi_resp_valid_o,
  input  logic                            dmi_resp_ready_i,
  output dmi_data_t                       dmi_resp_data_o,
  // hart side
  input  hart_mask_t                      halted_i,
  input  hart_mask_t                      unavailable_i,
  input  hart_mask_t                      resumeack_i,
  output hartsel_t                        hartsel_o,
  output hart_mask_t                      haltreq_o,
  output hart_mask_t                      resumereq_o,
  output logic                            clear_resumeack_o,
  output logic                            ndmreset_o,
  output logic                            dmactive_o,
  // command side
  output logic                            cmd_valid_o,
  output dmi_data_t                       cmd_o,
  input  logic                            cmderror_valid_i,
  input  cmderr_e                         cmderror_i,
  input  logic                            cmdbusy_i,
  output dmi_data_t [`DM_DATA_COUNT-1:0]  data_o,
  input  dmi_data_t [`DM_DATA_COUNT-1:0]  data_i,
  input  logic                            data_valid_i
);

  localparam int unsigned idx_w = $clog2(`DM_DATA_COUNT);

  logic             req_accept;
  logic             is_read;
  logic             is_write;
  logic             in_data;
  logic [idx_w-1:0] data_idx;
  logic             resp_full;
  logic             resp_empty;
  dmi_data_t        rd_word;
  dmi_data_t        dmcontrol;
  dmi_data_t        dmstatus;
  dmi_data_t        haltsum0;
  dmi_data_t        abstractcs;
  dmi_data_t        data_rd;

  // ----------------------------------------
  // request decode
  // ----------------------------------------
  assign dmi_req_ready_o  = ~resp_full;
  assign dmi_resp_valid_o = ~resp_empty;

  assign req_accept = dmi_req_valid_i & dmi_req_ready_o;
  assign is_read    = req_accept & (dmi_req_op_i == dtm_read);
  assign is_write   = req_accept & (dmi_req_op_i == dtm_write);

  assign in_data  = (dmi_req_addr_i >= `DM_ADDR_DATA0) &&
                    (dmi_req_addr_i < dmi_addr_t'(`DM_ADDR_DATA0 + `DM_DATA_COUNT));
  assign data_idx = idx_w'(dmi_req_addr_i - `DM_ADDR_DATA0);

  // read word comes from register state before this cycle's write
  always_comb begin
    rd_word = '0;
    if (in_data) begin
      rd_word = data_rd;
    end else begin
      case (dmi_req_addr_i)
        `DM_ADDR_DMCONTROL:  rd_word = dmcontrol;
        `DM_ADDR_DMSTATUS:   rd_word = dmstatus;
        `DM_ADDR_ABSTRACTCS: rd_word = abstractcs;
        `DM_ADDR_HALTSUM0:   rd_word = haltsum0;
        // command and unmapped addresses
        default:             rd_word = '0;
      endcase
    end
  end

  // ----------------------------------------
  // blocks
  // ----------------------------------------
  dm_resp_fifo u_resp_fifo (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .push_i      (req_accept),
    .push_data_i (is_read ? rd_word : '0),
    .pop_i       (dmi_resp_ready_i & ~resp_empty),
    .full_o      (resp_full),
    .empty_o     (resp_empty),
    .head_data_o (dmi_resp_data_o)
  );

  dm_hart_ctrl u_hart_ctrl (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .wr_dmcontrol_i    (is_write && dmi_req_addr_i == `DM_ADDR_DMCONTROL),
    .wr_data_i         (dmi_req_data_i),
    .halted_i          (halted_i),
    .unavailable_i     (unavailable_i),
    .resumeack_i       (resumeack_i),
    .dmcontrol_o       (dmcontrol),
    .dmstatus_o        (dmstatus),
    .haltsum0_o        (haltsum0),
    .hartsel_o         (hartsel_o),
    .haltreq_o         (haltreq_o),
    .resumereq_o       (resumereq_o),
    .clear_resumeack_o (clear_resumeack_o),
    .ndmreset_o        (ndmreset_o),
    .dmactive_o        (dmactive_o)
  );

  dm_abstract_cmd u_abstract_cmd (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .dmactive_i       (dmactive_o),
    .wr_command_i     (is_write && dmi_req_addr_i == `DM_ADDR_COMMAND),
    .wr_abstractcs_i  (is_write && dmi_req_addr_i == `DM_ADDR_ABSTRACTCS),
    .wr_data_i        (is_write & in_data),
    .rd_data_i        (is_read & in_data),
    .data_idx_i       (data_idx),
    .req_data_i       (dmi_req_data_i),
    .cmdbusy_i        (cmdbusy_i),
    .cmderror_valid_i (cmderror_valid_i),
    .cmderror_i       (cmderror_i),
    .data_valid_i     (data_valid_i),
    .data_i           (data_i),
    .abstractcs_o     (abstractcs),
    .data_rd_o        (data_rd),
    .cmd_valid_o      (cmd_valid_o),
    .cmd_o            (cmd_o),
    .data_o           (data_o)
  );

endmodule

/* hw/dm_defs.svh */
// ----------------------------------------
// build-time sizes and register map of the debug module front end
// DM_HARTSEL_W must cover DM_NR_HARTS - 1
// DM_DATA_COUNT of at least 2 keeps the data index one bit or wider
// ----------------------------------------

`ifndef DM_DEFS_SVH
`define DM_DEFS_SVH

// hart and register counts
`define DM_NR_HARTS 4
`define DM_HARTSEL_W 2
`define DM_DATA_COUNT 2

// entries in the DMI response queue
`define DM_RESP_DEPTH 2

// dmstatus.version, 2 is spec 0.13
`define DM_VERSION 2

// ----------------------------------------
// DMI register addresses
// ----------------------------------------
`define DM_ADDR_DATA0 7'h04
`define DM_ADDR_DMCONTROL 7'h10
`define DM_ADDR_DMSTATUS 7'h11
`define DM_ADDR_ABSTRACTCS 7'h16
`define DM_ADDR_COMMAND 7'h17
`define DM_ADDR_HALTSUM0 7'h40

`endif

/* hw/dm_hart_ctrl.sv */
// ----------------------------------------
// dmcontrol, havereset tracking and hart status words
// hasel, hartreset and the resethaltreq bits are not implemented
// haltsum0 only covers the first 32 harts
// ----------------------------------------

`timescale 1ns/100ps

`include "dm_defs.svh"

module dm_hart_ctrl import dm_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       wr_dmcontrol_i,
  input  dmi_data_t  wr_data_i,
  input  hart_mask_t halted_i,
  input  hart_mask_t unavailable_i,
  input  hart_mask_t resumeack_i,
  output dmi_data_t  dmcontrol_o,
  output dmi_data_t  dmstatus_o,
  output dmi_data_t  haltsum0_o,
  output hartsel_t   hartsel_o,
  output hart_mask_t haltreq_o,
  output hart_mask_t resumereq_o,
  output logic       clear_resumeack_o,
  output logic       ndmreset_o,
  output logic       dmactive_o
);

  localparam int unsigned nr_harts = `DM_NR_HARTS;

  logic                     haltreq_q;
  logic                     resumereq_q;
  logic                     ndmreset_q;
  logic                     dmactive_q;
  hartsel_t                 hartsel_q;
  hart_mask_t               havereset_q;
  hart_mask_t               havereset_d;
  logic [`DM_HARTSEL_W-1:0] sel_idx;
  logic                     sel_exists;
  logic                     sel_halted;
  logic                     sel_running;
  logic                     sel_unavail;
  logic                     sel_resumeack;
  logic                     sel_havereset;
  logic                     resume_done;
  logic                     dm_clear;

  // ----------------------------------------
  // selected hart status
  // ----------------------------------------
  assign sel_idx    = hartsel_q[`DM_HARTSEL_W-1:0];
  assign sel_exists = (hartsel_q < hartsel_t'(nr_harts));

  // unavailable wins over halted and running
  assign sel_unavail   = sel_exists & unavailable_i[sel_idx];
  assign sel_halted    = sel_exists & halted_i[sel_idx] & ~sel_unavail;
  assign sel_running   = sel_exists & ~halted_i[sel_idx] & ~sel_unavail;
  assign sel_resumeack = sel_exists & resumeack_i[sel_idx];
  assign sel_havereset = sel_exists & havereset_q[sel_idx];

  // ----------------------------------------
  // dmcontrol
  // ----------------------------------------
  // dmactive low, or a write that drops it, clears every other field
  assign dm_clear    = ~dmactive_q | (wr_dmcontrol_i & ~wr_data_i[0]);
  assign resume_done = resumereq_q & sel_resumeack;

  // the hart drops its old resumeack when a new resume starts
  assign clear_resumeack_o = wr_dmcontrol_i & ~dm_clear & wr_data_i[30] & ~resumereq_q;

  always_comb begin
    havereset_d = havereset_q;
    if (wr_dmcontrol_i && wr_data_i[28] && sel_exists) begin
      havereset_d[sel_idx] = 1'b0;
    end
    // a system reset counts as a reset of every hart
    if (ndmreset_q) begin
      havereset_d = '1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      haltreq_q   <= 1'b0;
      resumereq_q <= 1'b0;
      ndmreset_q  <= 1'b0;
      dmactive_q  <= 1'b0;
      hartsel_q   <= '0;
      havereset_q <= '1;
    end else begin
      havereset_q <= havereset_d;
      if (wr_dmcontrol_i) begin
        dmactive_q <= wr_data_i[0];
      end
      if (dm_clear) begin
        haltreq_q   <= 1'b0;
        resumereq_q <= 1'b0;
        ndmreset_q  <= 1'b0;
        hartsel_q   <= '0;
      end else if (wr_dmcontrol_i) begin
        haltreq_q   <= wr_data_i[31];
        resumereq_q <= wr_data_i[30] & ~resume_done;
        ndmreset_q  <= wr_data_i[1];
        hartsel_q   <= {wr_data_i[15:6], wr_data_i[25:16]};
      end else if (resume_done) begin
        resumereq_q <= 1'b0;
      end
    end
  end

  // ----------------------------------------
  // hart requests and read words
  // ----------------------------------------
  always_comb begin
    haltreq_o   = '0;
    resumereq_o = '0;
    if (sel_exists) begin
      haltreq_o[sel_idx]   = haltreq_q;
      resumereq_o[sel_idx] = resumereq_q;
    end
  end

  // ackhavereset reads back as zero
  assign dmcontrol_o = {haltreq_q, resumereq_q, 4'b0, hartsel_q[9:0], hartsel_q[19:10],
                        4'b0, ndmreset_q, dmactive_q};

  assign dmstatus_o = {12'b0, {2{sel_havereset}}, {2{sel_resumeack}}, {2{~sel_exists}},
                       {2{sel_unavail}}, {2{sel_running}}, {2{sel_halted}},
                       1'b1, 3'b0, 4'(`DM_VERSION)};

  // hartsel[19:5] picks the window of 32 harts
  assign haltsum0_o = (hartsel_q[19:5] == '0) ? 32'(halted_i) : '0;

  assign hartsel_o  = hartsel_q;
  assign ndmreset_o = ndmreset_q;
  assign dmactive_o = dmactive_q;

endmodule

/* hw/dm_pkg.sv */
// ----------------------------------------
// types shared by the debug module RTL and its testbench
// hart_mask_t follows DM_NR_HARTS from dm_defs.svh
// ----------------------------------------

`include "dm_defs.svh"

package dm_pkg;

  // DMI request fields
  typedef logic [6:0] dmi_addr_t;
  typedef logic [31:0] dmi_data_t;

  // operation code of a DMI request
  typedef enum logic [1:0] {
    dtm_nop   = 2'h0,
    dtm_read  = 2'h1,
    dtm_write = 2'h2
  } dtm_op_e;

  // abstractcs.cmderr codes, value 6 is reserved
  typedef enum logic [2:0] {
    cmderr_none          = 3'h0,
    cmderr_busy          = 3'h1,
    cmderr_not_supported = 3'h2,
    cmderr_exception     = 3'h3,
    cmderr_halt_resume   = 3'h4,
    cmderr_bus           = 3'h5,
    cmderr_other         = 3'h7
  } cmderr_e;

  // hartsel as {hartselhi, hartsello}
  typedef logic [19:0] hartsel_t;

  // one bit per hart
  typedef logic [`DM_NR_HARTS-1:0] hart_mask_t;

endpackage

/* hw/dm_resp_fifo.sv */
// ----------------------------------------
// in-order queue of DMI response words
// caller must not push when full or pop when empty
// ----------------------------------------

`timescale 1ns/100ps

`include "dm_defs.svh"

module dm_resp_fifo import dm_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      push_i,
  input  dmi_data_t push_data_i,
  input  logic      pop_i,
  output logic      full_o,
  output logic      empty_o,
  output dmi_data_t head_data_o
);

  localparam int unsigned depth = `DM_RESP_DEPTH;
  localparam int unsigned ptr_w = (depth > 1) ? $clog2(depth) : 1;
  localparam int unsigned cnt_w = $clog2(depth + 1);

  dmi_data_t        mem_q [depth];
  logic [ptr_w-1:0] wr_ptr_q;
  logic [ptr_w-1:0] rd_ptr_q;
  logic [cnt_w-1:0] count_q;

  // wrap explicitly so a depth that is not a power of two also works
  function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] ptr);
    if (ptr == ptr_w'(depth - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (pop_i) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      // simultaneous push and pop leave the count as is
      if (push_i && !pop_i) begin
        count_q <= count_q + 1'b1;
      end else if (!push_i && pop_i) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

  assign full_o      = (count_q == cnt_w'(depth));
  assign empty_o     = (count_q == '0);
  assign head_data_o = mem_q[rd_ptr_q];

endmodule

/* list.f */
+incdir+hw
hw/dm_pkg.sv
hw/dm_resp_fifo.sv
hw/dm_hart_ctrl.sv
hw/dm_abstract_cmd.sv
hw/dm_csrs.sv
test/dm_csrs_asserts.sv
test/tb_dm_csrs.sv

/* test/dm_csrs_asserts.sv */
// ----------------------------------------
// concurrent checks on the DMI handshake and control pulses
// bound into every dm_csrs instance
// fail_count is read by the testbench at the end of the run
// ----------------------------------------

`timescale 1ns/100ps

`include "dm_defs.svh"

module dm_csrs_asserts import dm_pkg::*; (
  input logic       clk_i,
  input logic       rst_ni,
  input logic       req_valid_i,
  input logic       req_ready_i,
  input logic       resp_valid_i,
  input logic       resp_ready_i,
  input logic       cmd_valid_i,
  input logic       clear_resumeack_i,
  input hart_mask_t haltreq_i
);

  int unsigned fail_count = 0;
  int unsigned occupancy;
  logic        accept;
  logic        pop;

  // queue fill level as seen from the DMI ports
  assign accept = req_valid_i & req_ready_i;
  assign pop    = resp_valid_i & resp_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      occupancy <= 0;
    end else if (accept && !pop) begin
      occupancy <= occupancy + 1;
    end else if (!accept && pop) begin
      occupancy <= occupancy - 1;
    end
  end

  // ----------------------------------------
  // DMI handshake
  // ----------------------------------------
  resp_latency: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (req_valid_i && req_ready_i && !resp_valid_i) |=> resp_valid_i)
  else begin
    fail_count++;
    $error("response not valid one cycle after acceptance into an empty queue");
  end

  no_accept_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (occupancy == `DM_RESP_DEPTH) |-> !(req_valid_i && req_ready_i))
  else begin
    fail_count++;
    $error("request accepted while the response queue is full");
  end

  // ----------------------------------------
  // control pulses
  // ----------------------------------------
  cmd_valid_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    cmd_valid_i |=> !cmd_valid_i)
  else begin
    fail_count++;
    $error("cmd_valid_o high for more than one cycle");
  end

  clear_resumeack_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    clear_resumeack_i |=> !clear_resumeack_i)
  else begin
    fail_count++;
    $error("clear_resumeack_o high for more than one cycle");
  end

  haltreq_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(haltreq_i))
  else begin
    fail_count++;
    $error("haltreq_o has more than one bit set");
  end

endmodule

bind dm_csrs dm_csrs_asserts u_asserts (
  .clk_i             (clk_i),
  .rst_ni            (rst_ni),
  .req_valid_i       (dmi_req_valid_i),
  .req_ready_i       (dmi_req_ready_o),
  .resp_valid_i      (dmi_resp_valid_o),
  .resp_ready_i      (dmi_resp_ready_i),
  .cmd_valid_i       (cmd_valid_o),
  .clear_resumeack_i (clear_resumeack_o),
  .haltreq_i         (haltreq_o)
);

/* test/tb_dm_csrs.sv */
// ----------------------------------------
// testbench of the DMI register front end
// responses are popped at once except in the back-pressure test
// expects the default build of 4 harts and 2 data registers
// ----------------------------------------

`timescale 1ns/100ps

`include "dm_defs.svh"

module tb_dm_csrs import dm_pkg::*; ();

  localparam int timeout_cycles = 200;

  logic clk = 1'b0;
  logic rst_n;
  logic req_valid, req_ready, resp_valid, resp_ready;
  dmi_addr_t req_addr;
  dtm_op_e req_op;
  dmi_data_t req_data, resp_data, cmd, rdata;
  hart_mask_t halted, unavailable, resumeack, haltreq, resumereq;
  hartsel_t hartsel;
  logic clear_resumeack, ndmreset, dmactive, cmd_valid, cmdbusy, cmderror_valid, data_valid;
  cmderr_e cmderror;
  dmi_data_t [`DM_DATA_COUNT-1:0] data_in;
  dmi_data_t [`DM_DATA_COUNT-1:0] data_out;

  int errors = 0, test_errors = 0, tests_run = 0, tests_failed = 0;
  int accepts = 0, cmd_pulses = 0, clr_pulses = 0, prev, n;
  logic timed_out = 1'b0;
  string test_name;
  integer seed = 32'h3bbb_a336;
  // reference model of the registers
  dmi_data_t m_dmcontrol, m_command;
  dmi_data_t m_data [`DM_DATA_COUNT];
  logic [2:0] m_cmderr;

  dm_csrs u_dut (
    .clk_i (clk), .rst_ni (rst_n),
    .dmi_req_valid_i (req_valid), .dmi_req_ready_o (req_ready), .dmi_req_addr_i (req_addr),
    .dmi_req_op_i (req_op), .dmi_req_data_i (req_data), .dmi_resp_valid_o (resp_valid),
    .dmi_resp_ready_i (resp_ready), .dmi_resp_data_o (resp_data),
    .halted_i (halted), .unavailable_i (unavailable), .resumeack_i (resumeack),
    .hartsel_o (hartsel), .haltreq_o (haltreq), .resumereq_o (resumereq),
    .clear_resumeack_o (clear_resumeack), .ndmreset_o (ndmreset), .dmactive_o (dmactive),
    .cmd_valid_o (cmd_valid), .cmd_o (cmd), .cmderror_valid_i (cmderror_valid),
    .cmderror_i (cmderror), .cmdbusy_i (cmdbusy), .data_o (data_out), .data_i (data_in),
    .data_valid_i (data_valid)
  );

  always #2 clk = ~clk;

  // sampled at the falling edge where everything is settled
  always @(negedge clk) begin
    if (req_valid && req_ready) accepts++;
    if (cmd_valid) cmd_pulses++;
    if (clear_resumeack) clr_pulses++;
  end

  // ----------------------------------------
  // expected register words
  // ----------------------------------------
  function automatic dmi_data_t dmstatus_word(logic exists, logic hlt, logic unav,
                                              logic rack, logic hrst);
    dmi_data_t w;
    w = 32'(`DM_VERSION);
    w[7] = 1'b1;
    w[9:8] = {2{exists & hlt & ~unav}};
    w[11:10] = {2{exists & ~hlt & ~unav}};
    w[13:12] = {2{exists & unav}};
    w[15:14] = {2{~exists}};
    w[17:16] = {2{rack}};
    w[19:18] = {2{hrst}};
    return w;
  endfunction

  function automatic dmi_data_t abstractcs_word(logic busy, logic [2:0] err);
    return 32'(`DM_DATA_COUNT) | (32'(err) << 8) | (32'(busy) << 12);
  endfunction

  // only dmactive is writable while inactive, or when the write drops it
  function automatic dmi_data_t dmcontrol_after(logic active, dmi_data_t w);
    if (!active || !w[0]) return {31'b0, w[0]};
    return w & 32'hc3ff_ffc3;
  endfunction

  // ----------------------------------------
  // reporting and DMI driver
  // ----------------------------------------
  task automatic start_test(string name);
    test_name = name;
    test_errors = 0;
  endtask

  task automatic end_test();
    tests_run++;
    if (test_errors != 0 || timed_out) begin
      tests_failed++;
      $display("%s: failed, %0d errors", test_name, test_errors);
    end else begin
      $display("%s: passed", test_name);
    end
  endtask

  task automatic check(string what, dmi_data_t exp, dmi_data_t act);
    assert (act === exp) else begin
      $display("** Error %s %s: expected %h, actual %h", test_name, what, exp, act);
      errors++;
      test_errors++;
    end
  endtask

  task automatic send_req(dtm_op_e op, dmi_addr_t addr, dmi_data_t data);
    int cnt;
    cnt = 0;
    @(posedge clk);
    req_valid <= 1'b1;
    req_op <= op;
    req_addr <= addr;
    req_data <= data;
    @(negedge clk);
    while (!req_ready && !timed_out) begin
      cnt++;
      if (cnt > timeout_cycles) begin
        $display("timeout: request to address %h was never accepted", addr);
        timed_out = 1'b1;
      end
      @(negedge clk);
    end
    @(posedge clk);
    req_valid <= 1'b0;
  endtask

  task automatic get_resp(output dmi_data_t d);
    int cnt;
    cnt = 0;
    @(negedge clk);
    while (!resp_valid && !timed_out) begin
      cnt++;
      if (cnt > timeout_cycles) begin
        $display("timeout: no DMI response arrived");
        timed_out = 1'b1;
      end
      @(negedge clk);
    end
    d = resp_data;
  endtask

  task automatic dmi_write(dmi_addr_t addr, dmi_data_t data);
    dmi_data_t d;
    send_req(dtm_write, addr, data);
    get_resp(d);
    check("write response", '0, d);
  endtask

  task automatic read_check(string what, dmi_addr_t addr, dmi_data_t exp);
    dmi_data_t d;
    send_req(dtm_read, addr, '0);
    get_resp(d);
    check(what, exp, d);
  endtask

  task automatic write_dmcontrol(dmi_data_t w);
    m_dmcontrol = dmcontrol_after(m_dmcontrol[0], w);
    dmi_write(`DM_ADDR_DMCONTROL, w);
  endtask

  // ----------------------------------------
  // test sequence
  // ----------------------------------------
  initial begin
    rst_n = 1'b0;
    {req_valid, req_addr, req_data, cmdbusy, cmderror_valid, data_valid} = '0;
    req_op = dtm_nop;
    resp_ready = 1'b1;
    {halted, unavailable, resumeack} = '0;
    cmderror = cmderr_none;
    data_in = '0;
    m_dmcontrol = '0;
    m_command = '0;
    m_cmderr = '0;
    foreach (m_data[i]) m_data[i] = '0;
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;

    start_test("reset");
    @(negedge clk);
    check("dmi_req_ready_o", 1, req_ready);
    check("control outputs", '0,
          {resp_valid, cmd_valid, haltreq, resumereq, clear_resumeack, ndmreset, dmactive});
    read_check("dmstatus", `DM_ADDR_DMSTATUS, dmstatus_word(1, 0, 0, 0, 1));
    end_test();

    start_test("backpressure");
    prev = accepts;
    @(posedge clk);
    resp_ready <= 1'b0;
    send_req(dtm_read, `DM_ADDR_DMSTATUS, '0);
    send_req(dtm_read, `DM_ADDR_ABSTRACTCS, '0);
    @(posedge clk);
    req_valid <= 1'b1;
    req_addr <= `DM_ADDR_HALTSUM0;
    repeat (4) begin
      @(negedge clk);
      check("ready while full", 0, req_ready);
    end
    @(posedge clk);
    req_valid <= 1'b0;
    resp_ready <= 1'b1;
    check("accepted requests", prev + 2, accepts);
    get_resp(rdata);
    check("first response", dmstatus_word(1, 0, 0, 0, 1), rdata);
    get_resp(rdata);
    check("second response", abstractcs_word(0, 0), rdata);
    end_test();

    start_test("dmcontrol");
    write_dmcontrol(32'h0000_0001);
    check("dmactive_o", 1, dmactive);
    write_dmcontrol(32'h8002_0001);
    check("haltreq_o", 4'b0100, haltreq);
    check("hartsel_o", 32'd2, hartsel);
    read_check("dmcontrol", `DM_ADDR_DMCONTROL, m_dmcontrol);
    @(posedge clk);
    halted <= 4'b0100;
    unavailable <= 4'b1000;
    read_check("dmstatus halted", `DM_ADDR_DMSTATUS, dmstatus_word(1, 1, 0, 0, 1));
    read_check("haltsum0", `DM_ADDR_HALTSUM0, 32'h4);
    prev = clr_pulses;
    write_dmcontrol(32'h4002_0001);
    check("clear_resumeack pulses", prev + 1, clr_pulses);
    check("resumereq_o", 4'b0100, resumereq);
    @(posedge clk);
    resumeack <= 4'b0100;
    n = 0;
    @(negedge clk);
    while (resumereq != '0 && !timed_out) begin
      n++;
      if (n > timeout_cycles) begin
        $display("timeout: resumereq_o did not clear after resumeack");
        timed_out = 1'b1;
      end
      @(negedge clk);
    end
    m_dmcontrol[30] = 1'b0;
    read_check("dmcontrol after resume", `DM_ADDR_DMCONTROL, m_dmcontrol);
    write_dmcontrol(32'h1002_0001);
    read_check("dmstatus after ackhavereset", `DM_ADDR_DMSTATUS, dmstatus_word(1, 1, 0, 1, 0));
    @(posedge clk);
    {halted, unavailable, resumeack} <= '0;
    end_test();

    start_test("command");
    prev = cmd_pulses;
    m_command = $random(seed);
    dmi_write(`DM_ADDR_COMMAND, m_command);
    n = 0;
    @(posedge clk);
    while (cmd_pulses == prev && !timed_out) begin
      n++;
      if (n > timeout_cycles) begin
        $display("timeout: cmd_valid_o never pulsed after a command write");
        timed_out = 1'b1;
      end
      @(posedge clk);
    end
    check("cmd_valid pulses", prev + 1, cmd_pulses);
    check("cmd_o", m_command, cmd);
    read_check("command read", `DM_ADDR_COMMAND, '0);
    end_test();

    start_test("busy");
    @(posedge clk);
    cmdbusy <= 1'b1;
    prev = cmd_pulses;
    dmi_write(`DM_ADDR_COMMAND, ~m_command);
    m_cmderr = 3'd1;
    dmi_write(`DM_ADDR_DATA0, $random(seed));
    read_check("abstractcs while busy", `DM_ADDR_ABSTRACTCS, abstractcs_word(1, m_cmderr));
    @(posedge clk);
    cmdbusy <= 1'b0;
    @(posedge clk);
    check("cmd_o kept", m_command, cmd);
    check("cmd_valid pulses", prev, cmd_pulses);
    read_check("data0 kept", `DM_ADDR_DATA0, m_data[0]);
    dmi_write(`DM_ADDR_ABSTRACTCS, 32'h700);
    m_cmderr = '0;
    read_check("abstractcs cleared", `DM_ADDR_ABSTRACTCS, abstractcs_word(0, m_cmderr));
    @(posedge clk);
    cmderror_valid <= 1'b1;
    cmderror <= cmderr_exception;
    @(posedge clk);
    cmderror_valid <= 1'b0;
    m_cmderr = 3'd3;
    read_check("abstractcs from hart", `DM_ADDR_ABSTRACTCS, abstractcs_word(0, m_cmderr));
    // clear one bit only
    dmi_write(`DM_ADDR_ABSTRACTCS, 32'h100);
    m_cmderr = m_cmderr & ~3'b001;
    read_check("abstractcs partial clear", `DM_ADDR_ABSTRACTCS, abstractcs_word(0, m_cmderr));
    end_test();

    start_test("data");
    foreach (m_data[i]) begin
      m_data[i] = $random(seed);
      dmi_write(dmi_addr_t'(`DM_ADDR_DATA0 + i), m_data[i]);
    end
    foreach (m_data[i]) read_check("data write", dmi_addr_t'(`DM_ADDR_DATA0 + i), m_data[i]);
    @(posedge clk);
    foreach (m_data[i]) begin
      m_data[i] = $random(seed);
      data_in[i] <= m_data[i];
    end
    data_valid <= 1'b1;
    @(posedge clk);
    data_valid <= 1'b0;
    foreach (m_data[i]) begin
      read_check("data from hart", dmi_addr_t'(`DM_ADDR_DATA0 + i), m_data[i]);
      check("data_o", m_data[i], data_out[i]);
    end
    write_dmcontrol(32'h0);
    foreach (m_data[i]) m_data[i] = '0;
    m_command = '0;
    foreach (m_data[i]) read_check("data inactive", dmi_addr_t'(`DM_ADDR_DATA0 + i), m_data[i]);
    read_check("command inactive", `DM_ADDR_COMMAND, m_command);
    read_check("dmcontrol inactive", `DM_ADDR_DMCONTROL, m_dmcontrol);
    check("cmd_o inactive", m_command, cmd);
    end_test();

    $display("tests run %0d, failed %0d, check errors %0d, assertion failures %0d",
             tests_run, tests_failed, errors, u_dut.u_asserts.fail_count);
    if (errors == 0 && tests_failed == 0 && !timed_out && u_dut.u_asserts.fail_count == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule
